/* Makefile */
SIM      := verilator
TOP      := harness_tb
FILELIST := compile.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) logic/soc_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+logic
logic/bus_pkg.sv
logic/map_pkg.sv
logic/bus_arbiter.sv
logic/region_decoder.sv
logic/byte_sram.sv
logic/debug_regs.sv
logic/harness_top.sv
testbench/tb_clock.sv
testbench/harness_tb.sv

/* logic/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

`include "soc_cfg.svh"

module bus_arbiter (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              hart_req_i,
    input  bus_pkg::bus_req_t hart_bus_i,
    output logic              hart_ack_o,
    output bus_pkg::bus_rsp_t hart_rsp_o,
    input  logic              sba_req_i,
    input  bus_pkg::bus_req_t sba_bus_i,
    output logic              sba_ack_o,
    output bus_pkg::bus_rsp_t sba_rsp_o,
    output logic              fwd_req_o,
    output bus_pkg::bus_req_t fwd_bus_o,
    input  logic              fwd_ack_i,
    input  bus_pkg::bus_rsp_t fwd_rsp_i
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUED,
        ST_ACKING
    } state_e;

    state_e   state_q;
    master_e  gnt_q;
    master_e  pick;
    logic     gnt_req;
    logic     fwd_req_q;
    logic     fwd_busy_q;
    logic     ack_q;
    bus_rsp_t rsp_q;

    // Round robin, the master not granted last wins a tie
    always_comb begin
        if (hart_req_i && sba_req_i) begin
            pick = (gnt_q == MST_HART) ? MST_SBA : MST_HART;
        end else if (sba_req_i) begin
            pick = MST_SBA;
        end else begin
            pick = MST_HART;
        end
    end

    assign gnt_req = (gnt_q == MST_HART) ? hart_req_i : sba_req_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            // Hart wins the first tie
            gnt_q     <= MST_SBA;
            fwd_req_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            fwd_req_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (hart_req_i || sba_req_i) begin
                        gnt_q     <= pick;
                        fwd_req_q <= 1'b1;
                        state_q   <= ST_ISSUED;
                    end
                end
                ST_ISSUED: begin
                    if (fwd_ack_i) begin
                        ack_q   <= 1'b1;
                        state_q <= ST_ACKING;
                    end
                end
                ST_ACKING: begin
                    // Hold ack until the owner returns req to zero
                    if (!gnt_req) begin
                        ack_q   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_ISSUED && fwd_ack_i) begin
            rsp_q <= fwd_rsp_i;
        end
    end

    // Open from the forward pulse until the decoder answers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fwd_busy_q <= 1'b0;
        end else if (fwd_req_o) begin
            fwd_busy_q <= 1'b1;
        end else if (fwd_ack_i) begin
            fwd_busy_q <= 1'b0;
        end
    end

    assign fwd_req_o  = fwd_req_q;
    assign fwd_bus_o  = (gnt_q == MST_HART) ? hart_bus_i : sba_bus_i;
    assign hart_ack_o = ack_q && (gnt_q == MST_HART);
    assign sba_ack_o  = ack_q && (gnt_q == MST_SBA);
    assign hart_rsp_o = rsp_q;
    assign sba_rsp_o  = rsp_q;

    a_ack_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(hart_ack_o && sba_ack_o))
        else $error("both master acks high");

    a_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
        fwd_req_o |-> !fwd_busy_q)
        else $error("forward request while one is outstanding");

endmodule

`default_nettype wire

/* logic/bus_pkg.sv */
`default_nettype none

`include "soc_cfg.svh"

package bus_pkg;

    // Which master owns the bus
    typedef enum logic {
        MST_HART = 1'b0,
        MST_SBA  = 1'b1
    } master_e;

    // Held stable by the master while req is high
    typedef struct packed {
        logic                  we;
        logic [`ADDR_W-1:0]    addr;
        logic [`DATA_W/8-1:0]  be;
        logic [`DATA_W-1:0]    wdata;
    } bus_req_t;

    // Valid while ack is high
    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        logic               err;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* logic/byte_sram.sv */
`default_nettype none
`timescale 1ns/1ps

`include "soc_cfg.svh"

module byte_sram (
    input  logic                           clk_i,
    input  logic                           req_i,
    input  logic                           we_i,
    input  logic [$clog2(`SRAM_WORDS)-1:0] addr_i,
    input  logic [`DATA_W/8-1:0]           be_i,
    input  logic [`DATA_W-1:0]             wdata_i,
    output logic [`DATA_W-1:0]             rdata_o
);

    localparam int NBYTES = `DATA_W / 8;

    logic [`DATA_W-1:0]             mem [`SRAM_WORDS];
    logic [$clog2(`SRAM_WORDS)-1:0] raddr_q;

    // Byte lanes written independently
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Read address held until the next read
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            raddr_q <= addr_i;
        end
    end

    assign rdata_o = mem[raddr_q];

endmodule

`default_nettype wire

/* logic/debug_regs.sv */
`default_nettype none
`timescale 1ns/1ps

`include "soc_cfg.svh"

module debug_regs (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   bus_req_i,
    input  logic                   bus_we_i,
    input  map_pkg::dbg_reg_e      bus_idx_i,
    input  logic [`DMI_DATA_W-1:0] bus_wdata_i,
    output logic [`DATA_W-1:0]     bus_rdata_o,
    input  logic                   dmi_req_i,
    input  logic                   dmi_wr_i,
    input  logic [`DMI_ADDR_W-1:0] dmi_addr_i,
    input  logic [`DMI_DATA_W-1:0] dmi_wdata_i,
    output logic [`DMI_DATA_W-1:0] dmi_rdata_o,
    output logic                   debug_req_o
);
    import map_pkg::*;

    localparam logic [`DMI_ADDR_W-1:0] DMI_NREGS = 4;

    logic                   haltreq_q;
    logic [`DMI_DATA_W-1:0] data0_q;
    logic [`DMI_DATA_W-1:0] data1_q;
    logic [`DMI_DATA_W-1:0] bus_rdata_q;
    logic [`DMI_ADDR_W-1:0] dmi_ofs;
    logic                   dmi_hit;
    dbg_reg_e               dmi_idx;

    function automatic logic [`DMI_DATA_W-1:0] read_reg(input dbg_reg_e idx);
        logic [`DMI_DATA_W-1:0] val;
        val = '0;
        case (idx)
            DBG_CTRL:   val[0] = haltreq_q;
            DBG_DATA0:  val = data0_q;
            DBG_DATA1:  val = data1_q;
            DBG_STATUS: val[0] = haltreq_q;
            default:    val = '0;
        endcase
        return val;
    endfunction

    // DMI window starts at DMI_REG_OFS
    assign dmi_ofs = dmi_addr_i - `DMI_REG_OFS;
    assign dmi_hit = dmi_ofs < DMI_NREGS;
    assign dmi_idx = dbg_reg_e'(dmi_ofs[1:0]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            haltreq_q <= 1'b0;
            data0_q   <= '0;
            data1_q   <= '0;
        end else begin
            if (bus_req_i && bus_we_i) begin
                case (bus_idx_i)
                    DBG_CTRL:  haltreq_q <= bus_wdata_i[0];
                    DBG_DATA0: data0_q   <= bus_wdata_i;
                    DBG_DATA1: data1_q   <= bus_wdata_i;
                    default:   ;
                endcase
            end
            // Later assignment, so DMI wins a clash
            if (dmi_req_i && dmi_wr_i && dmi_hit) begin
                case (dmi_idx)
                    DBG_CTRL:  haltreq_q <= dmi_wdata_i[0];
                    DBG_DATA0: data0_q   <= dmi_wdata_i;
                    DBG_DATA1: data1_q   <= dmi_wdata_i;
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_req_i) begin
            bus_rdata_q <= read_reg(bus_idx_i);
        end
    end

    assign bus_rdata_o = {{(`DATA_W-`DMI_DATA_W){1'b0}}, bus_rdata_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dmi_rdata_o <= '0;
        end else if (dmi_req_i && !dmi_wr_i) begin
            dmi_rdata_o <= dmi_hit ? read_reg(dmi_idx) : '0;
        end
    end

    // Halt request to the core
    assign debug_req_o = haltreq_q;

    a_dmi_wr_qual: assert property (@(posedge clk_i) disable iff (rst_i)
        dmi_wr_i |-> dmi_req_i)
        else $error("DMI write without request");

endmodule

`default_nettype wire

/* logic/harness_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "soc_cfg.svh"

module harness_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   hart_req_i,
    input  bus_pkg::bus_req_t      hart_bus_i,
    output logic                   hart_ack_o,
    output bus_pkg::bus_rsp_t      hart_rsp_o,
    input  logic                   sba_req_i,
    input  bus_pkg::bus_req_t      sba_bus_i,
    output logic                   sba_ack_o,
    output bus_pkg::bus_rsp_t      sba_rsp_o,
    input  logic                   dmi_req_i,
    input  logic                   dmi_wr_i,
    input  logic [`DMI_ADDR_W-1:0] dmi_addr_i,
    input  logic [`DMI_DATA_W-1:0] dmi_wdata_i,
    output logic [`DMI_DATA_W-1:0] dmi_rdata_o,
    output logic                   debug_req_o
);
    import bus_pkg::*;
    import map_pkg::*;

    // Arbiter to decoder
    logic     fwd_req;
    bus_req_t fwd_bus;
    logic     fwd_ack;
    bus_rsp_t fwd_rsp;

    // Decoder to SRAM
    logic                           sram_req;
    logic                           sram_we;
    logic [$clog2(`SRAM_WORDS)-1:0] sram_addr;
    logic [`DATA_W/8-1:0]           sram_be;
    logic [`DATA_W-1:0]             sram_wdata;
    logic [`DATA_W-1:0]             sram_rdata;

    // Decoder to debug registers
    logic                   dbg_req;
    logic                   dbg_we;
    dbg_reg_e               dbg_idx;
    logic [`DMI_DATA_W-1:0] dbg_wdata;
    logic [`DATA_W-1:0]     dbg_rdata;

    bus_arbiter u_arbiter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .hart_req_i (hart_req_i),
        .hart_bus_i (hart_bus_i),
        .hart_ack_o (hart_ack_o),
        .hart_rsp_o (hart_rsp_o),
        .sba_req_i  (sba_req_i),
        .sba_bus_i  (sba_bus_i),
        .sba_ack_o  (sba_ack_o),
        .sba_rsp_o  (sba_rsp_o),
        .fwd_req_o  (fwd_req),
        .fwd_bus_o  (fwd_bus),
        .fwd_ack_i  (fwd_ack),
        .fwd_rsp_i  (fwd_rsp)
    );

    region_decoder u_decoder (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (fwd_req),
        .bus_i        (fwd_bus),
        .ack_o        (fwd_ack),
        .rsp_o        (fwd_rsp),
        .sram_req_o   (sram_req),
        .sram_we_o    (sram_we),
        .sram_addr_o  (sram_addr),
        .sram_be_o    (sram_be),
        .sram_wdata_o (sram_wdata),
        .sram_rdata_i (sram_rdata),
        .dbg_req_o    (dbg_req),
        .dbg_we_o     (dbg_we),
        .dbg_idx_o    (dbg_idx),
        .dbg_wdata_o  (dbg_wdata),
        .dbg_rdata_i  (dbg_rdata)
    );

    byte_sram u_sram (
        .clk_i   (clk_i),
        .req_i   (sram_req),
        .we_i    (sram_we),
        .addr_i  (sram_addr),
        .be_i    (sram_be),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

    debug_regs u_dbg (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus_req_i   (dbg_req),
        .bus_we_i    (dbg_we),
        .bus_idx_i   (dbg_idx),
        .bus_wdata_i (dbg_wdata),
        .bus_rdata_o (dbg_rdata),
        .dmi_req_i   (dmi_req_i),
        .dmi_wr_i    (dmi_wr_i),
        .dmi_addr_i  (dmi_addr_i),
        .dmi_wdata_i (dmi_wdata_i),
        .dmi_rdata_o (dmi_rdata_o),
        .debug_req_o (debug_req_o)
    );

endmodule

`default_nettype wire

/* logic/map_pkg.sv */
`default_nettype none

package map_pkg;

    // Decoded bus target
    typedef enum logic [1:0] {
        REG_SRAM,
        REG_DEBUG,
        REG_NONE
    } region_e;

    // Debug registers, STATUS is read-only
    typedef enum logic [1:0] {
        DBG_CTRL,
        DBG_DATA0,
        DBG_DATA1,
        DBG_STATUS
    } dbg_reg_e;

endpackage

`default_nettype wire

/* logic/region_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

`include "soc_cfg.svh"

module region_decoder (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           req_i,
    input  bus_pkg::bus_req_t              bus_i,
    output logic                           ack_o,
    output bus_pkg::bus_rsp_t              rsp_o,
    output logic                           sram_req_o,
    output logic                           sram_we_o,
    output logic [$clog2(`SRAM_WORDS)-1:0] sram_addr_o,
    output logic [`DATA_W/8-1:0]           sram_be_o,
    output logic [`DATA_W-1:0]             sram_wdata_o,
    input  logic [`DATA_W-1:0]             sram_rdata_i,
    output logic                           dbg_req_o,
    output logic                           dbg_we_o,
    output map_pkg::dbg_reg_e              dbg_idx_o,
    output logic [`DMI_DATA_W-1:0]         dbg_wdata_o,
    input  logic [`DATA_W-1:0]             dbg_rdata_i
);
    import map_pkg::*;

    localparam int BYTE_AW = $clog2(`DATA_W/8);
    localparam int WORD_AW = $clog2(`SRAM_WORDS);

    logic [`ADDR_W-1:0] sram_ofs;
    logic [`ADDR_W-1:0] dbg_ofs;
    region_e            region;
    region_e            region_q;
    logic               ack_q;

    // Offsets wrap below the base, so one compare per window
    assign sram_ofs = bus_i.addr - `SRAM_BASE;
    assign dbg_ofs  = bus_i.addr - `DBG_BASE;

    always_comb begin
        if (sram_ofs < `SRAM_LEN) begin
            region = REG_SRAM;
        end else if (dbg_ofs < `DBG_LEN) begin
            region = REG_DEBUG;
        end else begin
            region = REG_NONE;
        end
    end

    assign sram_req_o   = req_i && (region == REG_SRAM);
    assign sram_we_o    = bus_i.we;
    assign sram_addr_o  = sram_ofs[WORD_AW+BYTE_AW-1:BYTE_AW];
    assign sram_be_o    = bus_i.be;
    assign sram_wdata_o = bus_i.wdata;

    // One debug register per bus word
    assign dbg_req_o   = req_i && (region == REG_DEBUG);
    assign dbg_we_o    = bus_i.we;
    assign dbg_idx_o   = dbg_reg_e'(dbg_ofs[BYTE_AW+1:BYTE_AW]);
    assign dbg_wdata_o = bus_i.wdata[`DMI_DATA_W-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            region_q <= REG_NONE;
        end else begin
            ack_q <= req_i;
            if (req_i) begin
                region_q <= region;
            end
        end
    end

    assign ack_o = ack_q;

    always_comb begin
        rsp_o = '0;
        case (region_q)
            REG_SRAM:  rsp_o.rdata = sram_rdata_i;
            REG_DEBUG: rsp_o.rdata = dbg_rdata_i;
            default:   rsp_o.err   = 1'b1;
        endcase
    end

    a_one_target: assert property (@(posedge clk_i) disable iff (rst_i)
        !(sram_req_o && dbg_req_o))
        else $error("SRAM and debug strobes high together");

endmodule

`default_nettype wire

/* logic/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 64

// SRAM depth in bus words
`define SRAM_WORDS 1024

// Memory region, byte addressed
`define SRAM_BASE 32'h0000_0000
`define SRAM_LEN 32'h0000_2000

// Debug register region
`define DBG_BASE 32'h1200_0000
`define DBG_LEN 32'h0000_1000

// DMI port
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

// DMI address of debug register 0
`define DMI_REG_OFS 7'h04

`endif

/* testbench/harness_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "soc_cfg.svh"

module harness_tb;
    import bus_pkg::*;
    import map_pkg::*;

    localparam int TIMEOUT = 100;
    localparam int BE_W    = `DATA_W / 8;
    localparam int WORDS   = `SRAM_WORDS;

    typedef logic [`ADDR_W-1:0]     addr_t;
    typedef logic [BE_W-1:0]        be_t;
    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`DMI_ADDR_W-1:0] dmi_addr_t;
    typedef logic [`DMI_DATA_W-1:0] dmi_word_t;

    logic      clk;
    logic      rst;
    logic      hart_req;
    bus_req_t  hart_bus;
    logic      hart_ack;
    bus_rsp_t  hart_rsp;
    logic      sba_req;
    bus_req_t  sba_bus;
    logic      sba_ack;
    bus_rsp_t  sba_rsp;
    logic      dmi_req;
    logic      dmi_wr;
    dmi_addr_t dmi_addr;
    dmi_word_t dmi_wdata;
    dmi_word_t dmi_rdata;
    logic      debug_req;

    // Expected SRAM words and debug registers
    word_t     sram_model [WORDS];
    dmi_word_t reg_model [4];

    logic [15:0] lfsr_q;
    int          errors;
    int          tests;
    int          tests_failed;
    int          err0;

    tb_clock u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    harness_top u_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .hart_req_i  (hart_req),
        .hart_bus_i  (hart_bus),
        .hart_ack_o  (hart_ack),
        .hart_rsp_o  (hart_rsp),
        .sba_req_i   (sba_req),
        .sba_bus_i   (sba_bus),
        .sba_ack_o   (sba_ack),
        .sba_rsp_o   (sba_rsp),
        .dmi_req_i   (dmi_req),
        .dmi_wr_i    (dmi_wr),
        .dmi_addr_i  (dmi_addr),
        .dmi_wdata_i (dmi_wdata),
        .dmi_rdata_o (dmi_rdata),
        .debug_req_o (debug_req)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[`DATA_W-2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic bus_req_t make_req(input logic we, input addr_t addr, input be_t be,
                                          input word_t wdata);
        bus_req_t rq;
        rq.we    = we;
        rq.addr  = addr;
        rq.be    = be;
        rq.wdata = wdata;
        return rq;
    endfunction

    function automatic addr_t word_addr(input int idx);
        return addr_t'(`SRAM_BASE + idx * BE_W);
    endfunction

    function automatic addr_t dbg_addr(input dbg_reg_e r);
        return addr_t'(`DBG_BASE + int'(r) * BE_W);
    endfunction

    function automatic dmi_addr_t dmi_of(input dbg_reg_e r);
        return `DMI_REG_OFS + dmi_addr_t'(r);
    endfunction

    // CTRL keeps only haltreq, STATUS cannot be written
    function automatic void model_write(input dbg_reg_e r, input dmi_word_t d);
        case (r)
            DBG_CTRL: reg_model[DBG_CTRL] = {31'b0, d[0]};
            DBG_DATA0: reg_model[DBG_DATA0] = d;
            DBG_DATA1: reg_model[DBG_DATA1] = d;
            default: ;
        endcase
    endfunction

    function automatic dmi_word_t exp_reg(input dbg_reg_e r);
        if (r == DBG_STATUS) begin
            return {31'b0, reg_model[DBG_CTRL][0]};
        end
        return reg_model[r];
    endfunction

    function automatic logic ack_of(input master_e m);
        return (m == MST_HART) ? hart_ack : sba_ack;
    endfunction

    function automatic bus_rsp_t rsp_of(input master_e m);
        return (m == MST_HART) ? hart_rsp : sba_rsp;
    endfunction

    task automatic drive_port(input master_e m, input logic req, input bus_req_t rq);
        if (m == MST_HART) begin
            hart_req <= req;
            hart_bus <= rq;
        end else begin
            sba_req <= req;
            sba_bus <= rq;
        end
    endtask

    // One four-phase transaction on a master port
    task automatic bus_xfer(input master_e m, input bus_req_t rq, output bus_rsp_t rsp);
        int   n;
        logic seen;
        logic high;
        rsp  = '0;
        seen = 1'b0;
        n    = 0;
        @(posedge clk);
        drive_port(m, 1'b1, rq);
        while (!seen && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            if (ack_of(m)) begin
                seen = 1'b1;
                rsp  = rsp_of(m);
            end
        end
        drive_port(m, 1'b0, rq);
        if (!seen) begin
            errors++;
            $display("timeout: no ack on the %s port", m.name());
        end
        high = seen;
        n    = 0;
        while (high && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            high = ack_of(m);
        end
        if (high) begin
            errors++;
            $display("timeout: ack on the %s port never dropped", m.name());
        end
    endtask

    task automatic sram_write(input master_e m, input int idx, input be_t be, input word_t wd);
        bus_rsp_t rsp;
        bus_xfer(m, make_req(1'b1, word_addr(idx), be, wd), rsp);
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                sram_model[idx][b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        if (rsp.err !== 1'b0) begin
            errors++;
            $display("mismatch err: got %h expected %h", rsp.err, 1'b0);
        end
    endtask

    task automatic sram_check(input master_e m, input int idx);
        bus_rsp_t rsp;
        bus_xfer(m, make_req(1'b0, word_addr(idx), '0, '0), rsp);
        if (rsp.rdata !== sram_model[idx]) begin
            errors++;
            $display("mismatch rdata: got %h expected %h", rsp.rdata, sram_model[idx]);
        end
        if (rsp.err !== 1'b0) begin
            errors++;
            $display("mismatch err: got %h expected %h", rsp.err, 1'b0);
        end
    endtask

    task automatic dmi_write(input dmi_addr_t addr, input dmi_word_t data);
        @(posedge clk);
        dmi_req   <= 1'b1;
        dmi_wr    <= 1'b1;
        dmi_addr  <= addr;
        dmi_wdata <= data;
        @(posedge clk);
        dmi_req <= 1'b0;
        dmi_wr  <= 1'b0;
    endtask

    // Read data is registered one cycle after the request
    task automatic dmi_read(input dmi_addr_t addr, output dmi_word_t data);
        @(posedge clk);
        dmi_req  <= 1'b1;
        dmi_wr   <= 1'b0;
        dmi_addr <= addr;
        @(posedge clk);
        dmi_req <= 1'b0;
        @(posedge clk);
        data = dmi_rdata;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            errors++;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors > err_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_reset_state();
        @(posedge clk);
        if (hart_ack !== 1'b0) begin
            errors++;
            $display("mismatch hart_ack_o: got %h expected %h", hart_ack, 1'b0);
        end
        if (sba_ack !== 1'b0) begin
            errors++;
            $display("mismatch sba_ack_o: got %h expected %h", sba_ack, 1'b0);
        end
        if (debug_req !== 1'b0) begin
            errors++;
            $display("mismatch debug_req_o: got %h expected %h", debug_req, 1'b0);
        end
        if (dmi_rdata !== '0) begin
            errors++;
            $display("mismatch dmi_rdata_o: got %h expected %h", dmi_rdata, 32'h0);
        end
    endtask

    // Full write first, so unmasked bytes have a known value
    task automatic test_sram_byte_enables();
        int idx;
        for (int i = 0; i < 10; i++) begin
            idx = (i * 97) % WORDS;
            sram_write(MST_HART, idx, '1, take_bits(`DATA_W));
            sram_write(MST_HART, idx, be_t'(take_bits(BE_W)), take_bits(`DATA_W));
            sram_check(MST_HART, idx);
        end
    endtask

    task automatic test_shared_bus();
        word_t hd;
        word_t sd;
        hd = take_bits(`DATA_W);
        sd = take_bits(`DATA_W);
        fork
            sram_write(MST_HART, 500, '1, hd);
            sram_write(MST_SBA, 700, '1, sd);
        join
        fork
            sram_check(MST_HART, 500);
            sram_check(MST_SBA, 700);
        join
    endtask

    // 0x8000_0000 has zero word bits, so SRAM word 0 would catch a stray write
    task automatic test_unmapped();
        bus_rsp_t rsp;
        for (int w = 1; w >= 0; w--) begin
            bus_xfer(MST_HART, make_req(1'(w), 32'h8000_0000, '1, take_bits(`DATA_W)), rsp);
            if (rsp.err !== 1'b1) begin
                errors++;
                $display("mismatch err: got %h expected %h", rsp.err, 1'b1);
            end
            if (rsp.rdata !== '0) begin
                errors++;
                $display("mismatch rdata: got %h expected %h", rsp.rdata, word_t'(0));
            end
        end
        for (int i = 0; i < 10; i++) begin
            sram_check(MST_HART, (i * 97) % WORDS);
        end
    endtask

    task automatic test_debug_path();
        bus_rsp_t  rsp;
        dmi_word_t d;
        word_t     w;
        dmi_write(dmi_of(DBG_CTRL), 32'h1);
        model_write(DBG_CTRL, 32'h1);
        @(posedge clk);
        if (debug_req !== 1'b1) begin
            errors++;
            $display("mismatch debug_req_o: got %h expected %h", debug_req, 1'b1);
        end
        // DMI write, bus read
        d = dmi_word_t'(take_bits(`DMI_DATA_W));
        dmi_write(dmi_of(DBG_DATA0), d);
        model_write(DBG_DATA0, d);
        bus_xfer(MST_SBA, make_req(1'b0, dbg_addr(DBG_DATA0), '0, '0), rsp);
        if (rsp.rdata !== word_t'(exp_reg(DBG_DATA0)) || rsp.err !== 1'b0) begin
            errors++;
            $display("mismatch sba_rsp_o: got %h expected %h", rsp,
                     {word_t'(exp_reg(DBG_DATA0)), 1'b0});
        end
        // Bus write, DMI read, only the low half lands
        w = take_bits(`DATA_W);
        bus_xfer(MST_SBA, make_req(1'b1, dbg_addr(DBG_DATA1), '1, w), rsp);
        model_write(DBG_DATA1, w[`DMI_DATA_W-1:0]);
        dmi_read(dmi_of(DBG_DATA1), d);
        if (d !== exp_reg(DBG_DATA1)) begin
            errors++;
            $display("mismatch dmi_rdata_o: got %h expected %h", d, exp_reg(DBG_DATA1));
        end
        dmi_read(dmi_of(DBG_STATUS), d);
        if (d !== exp_reg(DBG_STATUS)) begin
            errors++;
            $display("mismatch dmi_rdata_o: got %h expected %h", d, exp_reg(DBG_STATUS));
        end
        bus_xfer(MST_SBA, make_req(1'b0, dbg_addr(DBG_STATUS), '0, '0), rsp);
        if (rsp.rdata !== word_t'(exp_reg(DBG_STATUS))) begin
            errors++;
            $display("mismatch sba_rsp_o.rdata: got %h expected %h", rsp.rdata,
                     word_t'(exp_reg(DBG_STATUS)));
        end
        // Below the register window, while haltreq and the last DMI read are still 1
        dmi_read(7'h00, d);
        if (d !== '0) begin
            errors++;
            $display("mismatch dmi_rdata_o: got %h expected %h", d, 32'h0);
        end
        // Clearing haltreq
        dmi_write(dmi_of(DBG_CTRL), 32'h0);
        model_write(DBG_CTRL, 32'h0);
        dmi_read(dmi_of(DBG_STATUS), d);
        if (debug_req !== 1'b0 || d !== exp_reg(DBG_STATUS)) begin
            errors++;
            $display("mismatch debug_req_o: got %h expected %h, status %h expected %h",
                     debug_req, 1'b0, d, exp_reg(DBG_STATUS));
        end
    endtask

    always @(posedge clk) begin
        if (hart_ack && sba_ack) begin
            errors++;
            $display("both master acks were high in the same cycle");
        end
    end

    initial begin
        hart_req     = 1'b0;
        hart_bus     = '0;
        sba_req      = 1'b0;
        sba_bus      = '0;
        dmi_req      = 1'b0;
        dmi_wr       = 1'b0;
        dmi_addr     = '0;
        dmi_wdata    = '0;
        lfsr_q       = 16'd99;
        errors       = 0;
        tests        = 0;
        tests_failed = 0;
        for (int i = 0; i < 4; i++) begin
            reg_model[i] = '0;
        end
        wait_reset();

        err0 = errors;
        test_reset_state();
        report_test("reset state", err0);
        err0 = errors;
        test_sram_byte_enables();
        report_test("sram byte enables", err0);
        err0 = errors;
        test_shared_bus();
        report_test("shared bus", err0);
        err0 = errors;
        test_unmapped();
        report_test("unmapped address", err0);
        err0 = errors;
        test_debug_path();
        report_test("debug path", err0);

        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Released on the eighth rising edge
    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire
